// File: besm_mmu_pkg.sv
`default_nettype none

package besm_mmu_pkg;

// -------------------------------------------------------------------------
// Widths
// -------------------------------------------------------------------------
localparam int AXIL_ADDR_W   = 13;          // Byte address on the bus
localparam int AXIL_DATA_W   = 32;
localparam int PAGE_CNT      = 1024;        // Pages in the map
localparam int PAGE_IDX_W    = 10;
localparam int PAGE_FRAME_W  = 20;          // Page map entry
localparam int MOD_GROUP_W   = 5;           // Modifier group number
localparam int MOD_NUM_W     = 5;           // Modifier within group
localparam int MOD_PRIV_BASE = 16;          // First modifier that needs MOD

// -------------------------------------------------------------------------
// Register map, byte offsets
// -------------------------------------------------------------------------
localparam logic [AXIL_ADDR_W-1:0] REG_MODGN  = 13'h000;   // Group number
localparam logic [AXIL_ADDR_W-1:0] REG_PHYSPG = 13'h004;   // Physical page
localparam logic [AXIL_ADDR_W-1:0] REG_PRIV   = 13'h008;   // Privilege flag
localparam logic [AXIL_ADDR_W-1:0] REG_FILL   = 13'h00C;   // Bit 0 busy / start
localparam logic [AXIL_ADDR_W-1:0] REG_ACCESS = 13'h010;   // {ro, inv, 0}
localparam logic [AXIL_ADDR_W-1:0] REG_REPRIO = 13'h014;   // Reprioritize bit
localparam logic [AXIL_ADDR_W-1:0] MOD_BASE   = 13'h100;   // 32 words, number in 6:2
localparam logic [AXIL_ADDR_W-1:0] MAP_BASE   = 13'h1000;  // 1024 words, page in 11:2

localparam logic [1:0] RESP_OKAY   = 2'b00;
localparam logic [1:0] RESP_SLVERR = 2'b10;

// Entry and address types
typedef logic [PAGE_IDX_W-1:0]            page_idx_t;
typedef logic [PAGE_FRAME_W-1:0]          page_frame_t;
typedef logic [31:0]                      mod_word_t;
typedef logic [MOD_GROUP_W+MOD_NUM_W-1:0] mod_addr_t;    // {group, number}

// Host side of the AXI4-Lite port
typedef struct packed {
    logic                     aw_valid;
    logic [AXIL_ADDR_W-1:0]   aw_addr;
    logic [2:0]               aw_prot;      // Not decoded
    logic                     w_valid;
    logic [AXIL_DATA_W-1:0]   w_data;
    logic [AXIL_DATA_W/8-1:0] w_strb;       // Full-word writes only
    logic                     b_ready;
    logic                     ar_valid;
    logic [AXIL_ADDR_W-1:0]   ar_addr;
    logic [2:0]               ar_prot;      // Not decoded
    logic                     r_ready;
} axil_m2s_t;

// Slave side of the AXI4-Lite port
typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    logic                   b_valid;
    logic [1:0]             b_resp;
    logic                   ar_ready;
    logic                   r_valid;
    logic [AXIL_DATA_W-1:0] r_data;
    logic [1:0]             r_resp;
} axil_s2m_t;

// Internal register request, valid for one cycle
typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_DATA_W-1:0] wdata;
} reg_req_t;

endpackage

`default_nettype wire

// File: mmu_ram.sv
`default_nettype none

module mmu_ram #(
    parameter type T     = logic [31:0],    // Entry type
    parameter int  DEPTH = 1024             // Number of entries
) (
    input  wire                     clk,    // System clock
    input  wire                     i_we,   // Write enable
    input  wire [$clog2(DEPTH)-1:0] i_addr, // Entry index
    input  wire T                   i_wdata,
    output T                        o_rdata // Registered read
);

T mem [DEPTH];                              // Storage array

always_ff @(posedge clk) begin
    if (i_we)
        mem[i_addr] <= i_wdata;
    o_rdata <= mem[i_addr];                 // Old entry on a write cycle
end

endmodule

`default_nettype wire

// File: axil_slave.sv
`default_nettype none

module axil_slave import besm_mmu_pkg::*; (
    input  wire                   clk,      // System clock
    input  wire                   reset,    // Synchronous, active high
    input  wire axil_m2s_t        i_axil,   // From host
    output axil_s2m_t             o_axil,   // To host
    output reg_req_t              o_req,    // One-cycle register request
    input  wire [AXIL_DATA_W-1:0] i_rdata,  // Read data one cycle after request
    input  wire [1:0]             i_resp    // Response code from decode
);

typedef enum logic [2:0] {
    ST_START,                               // Quiet cycle after reset
    ST_IDLE,                                // Collecting AW/W or AR
    ST_REQ,                                 // Request on o_req
    ST_WAIT,                                // Read data on the way
    ST_RESP                                 // B or R held until accepted
} state_t;

state_t                 state;
logic                   aw_pend;            // Write address captured
logic                   w_pend;             // Write data captured
logic                   aw_hs, w_hs, ar_hs; // Channel handshakes
logic                   resp_hs;            // B or R taken by host
logic                   wr_done;            // Both halves of a write in
logic                   idle;
logic                   wr_q;               // Current transaction is a write
logic [AXIL_ADDR_W-1:0] addr_q;
logic [AXIL_DATA_W-1:0] wdata_q;
logic [AXIL_DATA_W-1:0] rdata_q;
logic [1:0]             resp_q;

assign idle = (state == ST_IDLE);

// Ready only while idle, and AR loses to any write activity
always_comb begin
    o_axil          = '0;
    o_axil.aw_ready = idle & ~aw_pend;
    o_axil.w_ready  = idle & ~w_pend;
    o_axil.ar_ready = idle & ~aw_pend & ~w_pend & ~i_axil.aw_valid & ~i_axil.w_valid;
    o_axil.b_valid  = (state == ST_RESP) & wr_q;
    o_axil.b_resp   = resp_q;
    o_axil.r_valid  = (state == ST_RESP) & ~wr_q;
    o_axil.r_data   = rdata_q;
    o_axil.r_resp   = resp_q;
end

assign aw_hs   = i_axil.aw_valid & o_axil.aw_ready;
assign w_hs    = i_axil.w_valid & o_axil.w_ready;
assign ar_hs   = i_axil.ar_valid & o_axil.ar_ready;
assign wr_done = (aw_pend | aw_hs) & (w_pend | w_hs);
assign resp_hs = (o_axil.b_valid & i_axil.b_ready) | (o_axil.r_valid & i_axil.r_ready);

assign o_req = '{valid: (state == ST_REQ), write: wr_q, addr: addr_q, wdata: wdata_q};

// -------------------------------------------------------------------------
// Transaction sequencing
// -------------------------------------------------------------------------
always_ff @(posedge clk) begin
    if (reset) begin
        state   <= ST_START;
        aw_pend <= 1'b0;
        w_pend  <= 1'b0;
    end else begin
        case (state)
            ST_START: state <= ST_IDLE;
            ST_IDLE: begin
                if (wr_done) begin          // Write complete
                    state   <= ST_REQ;
                    aw_pend <= 1'b0;
                    w_pend  <= 1'b0;
                end else begin
                    aw_pend <= aw_pend | aw_hs;
                    w_pend  <= w_pend | w_hs;
                    if (ar_hs)
                        state <= ST_REQ;
                end
            end
            ST_REQ:  state <= wr_q ? ST_RESP : ST_WAIT;
            ST_WAIT: state <= ST_RESP;
            ST_RESP: begin
                if (resp_hs)
                    state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// Captured address, data and response
always_ff @(posedge clk) begin
    if (aw_hs)
        addr_q <= i_axil.aw_addr;
    else if (ar_hs)
        addr_q <= i_axil.ar_addr;
    if (w_hs)
        wdata_q <= i_axil.w_data;
    if (idle)
        wr_q <= wr_done;                    // Kind fixed on leaving idle
    if (state == ST_REQ || state == ST_WAIT) begin
        rdata_q <= i_rdata;                 // Last capture wins for reads
        resp_q  <= i_resp;
    end
end

endmodule

`default_nettype wire

// File: modifier_mem.sv
`default_nettype none

module modifier_mem import besm_mmu_pkg::*; (
    input  wire                   clk,      // System clock
    input  wire                   i_we,     // Host write
    input  wire [MOD_NUM_W-1:0]   i_num,    // Modifier number
    input  wire [MOD_GROUP_W-1:0] i_group,  // From group number register
    input  wire                   i_priv,   // Privilege flag
    input  wire mod_word_t        i_wdata,
    output mod_word_t             o_rdata   // Registered read
);

mod_addr_t addr;                            // {group, number}
mod_word_t ram_rdata;
logic      num_zero;                        // M0 is hardwired zero
logic      num_priv;                        // M16..M31
logic      blocked;                         // Access masked
logic      zero_q;                          // Mask in step with RAM read

assign num_zero = (i_num == '0);
assign num_priv = (i_num >= MOD_NUM_W'(MOD_PRIV_BASE));
assign blocked  = num_zero | (num_priv & ~i_priv);
assign addr     = {i_group, i_num};

mmu_ram #(
    .T     (mod_word_t),
    .DEPTH (2 ** $bits(mod_addr_t))
) i_mod_ram (
    .clk     (clk),
    .i_we    (i_we & ~blocked),             // Drop masked writes
    .i_addr  (addr),
    .i_wdata (i_wdata),
    .o_rdata (ram_rdata)
);

always_ff @(posedge clk)
    zero_q <= blocked;

assign o_rdata = zero_q ? '0 : ram_rdata;   // Masked reads give zero

endmodule

`default_nettype wire

// File: page_attr_mem.sv
`default_nettype none

module page_attr_mem import besm_mmu_pkg::*; (
    input  wire            clk,             // System clock
    input  wire            reset,           // Synchronous, active high
    input  wire page_idx_t i_page,          // Current physical page
    input  wire            i_access_we,     // Write ro/inv bits
    input  wire [1:0]      i_access_wdata,  // {ro, inv}
    input  wire            i_reprio_we,     // Write reprioritize bit
    input  wire            i_reprio_wdata,
    input  wire            i_fill_start,    // Start bulk fill from i_page
    output logic           o_fill_busy,
    output logic [2:0]     o_access,        // {ro, inv, 0}
    output logic           o_reprio
);

logic      inv_mem    [PAGE_CNT];           // Page invalid
logic      ro_mem     [PAGE_CNT];           // Page read-only
logic      reprio_mem [PAGE_CNT];           // Reprioritize request
page_idx_t fill_cnt;                        // Page being filled
logic      fill_busy;
logic      fill_last;                       // Filling page 1023

assign fill_last   = (fill_cnt == page_idx_t'(PAGE_CNT - 1));
assign o_fill_busy = fill_busy;

// -------------------------------------------------------------------------
// Fill engine, one page per cycle up to the top page
// -------------------------------------------------------------------------
always_ff @(posedge clk) begin
    if (reset) begin
        fill_busy <= 1'b0;
    end else if (fill_busy) begin
        if (fill_last)
            fill_busy <= 1'b0;              // Done after page 1023
    end else if (i_fill_start) begin
        fill_busy <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (fill_busy)
        fill_cnt <= fill_cnt + 1'b1;
    else if (i_fill_start)
        fill_cnt <= i_page;                 // Start at current page
end

// -------------------------------------------------------------------------
// Bit arrays
// -------------------------------------------------------------------------
always_ff @(posedge clk) begin
    if (i_access_we) begin
        ro_mem[i_page]  <= i_access_wdata[1];
        inv_mem[i_page] <= i_access_wdata[0];
    end
    if (fill_busy)
        reprio_mem[fill_cnt] <= 1'b1;       // Fill wins over host
    else if (i_reprio_we)
        reprio_mem[i_page] <= i_reprio_wdata;
    o_access <= {ro_mem[i_page], inv_mem[i_page], 1'b0};
    o_reprio <= reprio_mem[i_page];
end

endmodule

`default_nettype wire

// File: besm_mmu.sv
`default_nettype none

module besm_mmu import besm_mmu_pkg::*; (
    input  wire            clk,             // System clock
    input  wire            reset,           // Synchronous, active high
    input  wire axil_m2s_t i_axil,          // Host port in
    output axil_s2m_t      o_axil           // Host port out
);

typedef enum logic [3:0] {
    SRC_NONE,                               // Unmapped
    SRC_MODGN, SRC_PHYSPG, SRC_PRIV, SRC_FILL,
    SRC_ACCESS, SRC_REPRIO, SRC_MOD, SRC_MAP
} src_t;

reg_req_t               req;
logic [AXIL_DATA_W-1:0] rdata;
logic [1:0]             resp;
logic [MOD_GROUP_W-1:0] modgn;              // Modifier group number
page_idx_t              physpg;             // Physical page register
logic                   priv;               // Stands in for MOD bit
logic                   wr;                 // Write request this cycle
src_t                   src;                // Decoded target
src_t                   src_q;              // Target of last request
page_idx_t              map_addr;
logic [MOD_NUM_W-1:0]   mod_num;
page_frame_t            map_rdata;
mod_word_t              mod_rdata;
logic                   fill_busy;
logic [2:0]             access;
logic                   reprio;

axil_slave i_axil_slave (
    .clk     (clk),
    .reset   (reset),
    .i_axil  (i_axil),
    .o_axil  (o_axil),
    .o_req   (req),
    .i_rdata (rdata),
    .i_resp  (resp)
);

// -------------------------------------------------------------------------
// Address decode
// -------------------------------------------------------------------------
always_comb begin
    if (req.addr[AXIL_ADDR_W-1:12] == MAP_BASE[AXIL_ADDR_W-1:12])
        src = SRC_MAP;
    else if (req.addr[AXIL_ADDR_W-1:7] == MOD_BASE[AXIL_ADDR_W-1:7])
        src = SRC_MOD;
    else begin
        case (req.addr)
            REG_MODGN:  src = SRC_MODGN;
            REG_PHYSPG: src = SRC_PHYSPG;
            REG_PRIV:   src = SRC_PRIV;
            REG_FILL:   src = SRC_FILL;
            REG_ACCESS: src = SRC_ACCESS;
            REG_REPRIO: src = SRC_REPRIO;
            default:    src = SRC_NONE;
        endcase
    end
end

assign wr       = req.valid & req.write;
assign map_addr = (src == SRC_MAP) ? req.addr[11:2] : '0;
assign mod_num  = (src == SRC_MOD) ? req.addr[6:2] : '0;

// Writes answered now, reads from the latched target
assign resp = (req.valid ? (src == SRC_NONE) : (src_q == SRC_NONE)) ? RESP_SLVERR : RESP_OKAY;

// Control registers
always_ff @(posedge clk) begin
    if (reset) begin
        modgn  <= '0;
        physpg <= '0;
        priv   <= 1'b0;
        src_q  <= SRC_NONE;
    end else begin
        if (req.valid)
            src_q <= src;
        if (wr) begin
            case (src)
                SRC_MODGN:  modgn  <= req.wdata[MOD_GROUP_W-1:0];
                SRC_PHYSPG: physpg <= req.wdata[PAGE_IDX_W-1:0];
                SRC_PRIV:   priv   <= req.wdata[0];
                default:    ;
            endcase
        end
    end
end

// -------------------------------------------------------------------------
// Memories
// -------------------------------------------------------------------------
mmu_ram #(
    .T     (page_frame_t),
    .DEPTH (PAGE_CNT)
) i_page_map (
    .clk     (clk),
    .i_we    (wr && src == SRC_MAP),
    .i_addr  (map_addr),
    .i_wdata (req.wdata[PAGE_FRAME_W-1:0]),
    .o_rdata (map_rdata)
);

modifier_mem i_modifier_mem (
    .clk     (clk),
    .i_we    (wr && src == SRC_MOD),
    .i_num   (mod_num),
    .i_group (modgn),
    .i_priv  (priv),
    .i_wdata (req.wdata),
    .o_rdata (mod_rdata)
);

page_attr_mem i_page_attr_mem (
    .clk            (clk),
    .reset          (reset),
    .i_page         (physpg),
    .i_access_we    (wr && src == SRC_ACCESS),
    .i_access_wdata (req.wdata[2:1]),       // {ro, inv}
    .i_reprio_we    (wr && src == SRC_REPRIO),
    .i_reprio_wdata (req.wdata[0]),
    .i_fill_start   (wr && src == SRC_FILL && req.wdata[0]),
    .o_fill_busy    (fill_busy),
    .o_access       (access),
    .o_reprio       (reprio)
);

// Read data, zero-extended
always_comb begin
    case (src_q)
        SRC_MODGN:  rdata = AXIL_DATA_W'(modgn);
        SRC_PHYSPG: rdata = AXIL_DATA_W'(physpg);
        SRC_PRIV:   rdata = AXIL_DATA_W'(priv);
        SRC_FILL:   rdata = AXIL_DATA_W'(fill_busy);
        SRC_ACCESS: rdata = AXIL_DATA_W'(access);
        SRC_REPRIO: rdata = AXIL_DATA_W'(reprio);
        SRC_MOD:    rdata = mod_rdata;
        SRC_MAP:    rdata = AXIL_DATA_W'(map_rdata);
        default:    rdata = '0;             // Unmapped reads zero
    endcase
end

endmodule

`default_nettype wire

// File: tb_besm_mmu.sv
`default_nettype none

module tb_besm_mmu import besm_mmu_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int TIMEOUT = 100;               // Cycles per handshake
localparam int SEED    = 54676;

typedef enum int {
    K_NONE, K_MODGN, K_PHYSPG, K_PRIV, K_FILL, K_ACCESS, K_REPRIO, K_MOD, K_MAP
} kind_t;

logic      clk;
logic      reset;
axil_m2s_t m2s;                             // Host drive
axil_s2m_t s2m;                             // DUT response
int        error_count;
int        timeout_count;

// -------------------------------------------------------------------------
// Reference model state
// -------------------------------------------------------------------------
logic [MOD_GROUP_W-1:0] modgn_m;
page_idx_t              physpg_m;
logic                   priv_m;
logic                   fill_on;            // Fill started and not yet seen done
page_idx_t              fill_from;
logic [19:0]            map_m  [PAGE_CNT];
bit                     map_ok [PAGE_CNT];  // Entry written
logic [2:0]             acc_m  [PAGE_CNT];  // {ro, inv, 0}
bit                     acc_ok [PAGE_CNT];
logic                   rep_m  [PAGE_CNT];
bit                     rep_ok [PAGE_CNT];
logic [31:0]            mod_m  [32][32];    // [group][number]
bit                     mod_ok [32][32];

besm_mmu i_besm_mmu (
    .clk    (clk),
    .reset  (reset),
    .i_axil (m2s),
    .o_axil (s2m)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                  // 10 ns period
end

function automatic kind_t decode_addr(input logic [12:0] a);
    if (a >= MAP_BASE)
        return K_MAP;                       // 0x1000 .. 0x1FFF
    if (a >= MOD_BASE && a < MOD_BASE + 13'h80)
        return K_MOD;                       // 32 words
    case (a)
        REG_MODGN:  return K_MODGN;
        REG_PHYSPG: return K_PHYSPG;
        REG_PRIV:   return K_PRIV;
        REG_FILL:   return K_FILL;
        REG_ACCESS: return K_ACCESS;
        REG_REPRIO: return K_REPRIO;
        default:    return K_NONE;
    endcase
endfunction

function automatic void model_write(input logic [12:0] a, input logic [31:0] d);
    logic [4:0] n;
    n = a[6:2];
    case (decode_addr(a))
        K_MODGN:  modgn_m  = d[4:0];
        K_PHYSPG: physpg_m = d[9:0];
        K_PRIV:   priv_m   = d[0];
        K_FILL: begin
            if (d[0] && !fill_on) begin     // Start from current page
                fill_on   = 1'b1;
                fill_from = physpg_m;
            end
        end
        K_ACCESS: begin
            acc_m[physpg_m]  = {d[2:1], 1'b0};
            acc_ok[physpg_m] = 1'b1;
        end
        K_REPRIO: begin
            if (!fill_on) begin             // Dropped while busy
                rep_m[physpg_m]  = d[0];
                rep_ok[physpg_m] = 1'b1;
            end
        end
        K_MOD: begin
            if (n != 0 && (n < MOD_PRIV_BASE || priv_m)) begin
                mod_m[modgn_m][n]  = d;
                mod_ok[modgn_m][n] = 1'b1;
            end
        end
        K_MAP: begin
            map_m[a[11:2]]  = d[19:0];
            map_ok[a[11:2]] = 1'b1;
        end
        default: ;                          // Unmapped writes change nothing
    endcase
endfunction

function automatic void model_read(input logic [12:0] a, output logic [31:0] want,
                                   output bit known);
    logic [4:0] n;
    n     = a[6:2];
    want  = '0;
    known = 1'b1;
    case (decode_addr(a))
        K_MODGN:  want  = 32'(modgn_m);
        K_PHYSPG: want  = 32'(physpg_m);
        K_PRIV:   want  = 32'(priv_m);
        K_FILL:   known = !fill_on;         // Busy reads 0 when idle
        K_ACCESS: begin
            want  = 32'(acc_m[physpg_m]);
            known = acc_ok[physpg_m];
        end
        K_REPRIO: begin
            want  = 32'(rep_m[physpg_m]);
            known = rep_ok[physpg_m];
        end
        K_MOD: begin
            if (n != 0 && (n < MOD_PRIV_BASE || priv_m)) begin
                want  = mod_m[modgn_m][n];
                known = mod_ok[modgn_m][n];
            end
        end
        K_MAP: begin
            want  = 32'(map_m[a[11:2]]);
            known = map_ok[a[11:2]];
        end
        default: ;                          // Unmapped reads zero
    endcase
endfunction

// Once the fill is done every page from the start page up is set
function automatic void fill_done();
    for (int p = int'(fill_from); p < PAGE_CNT; p++) begin
        rep_m[p]  = 1'b1;
        rep_ok[p] = 1'b1;
    end
    fill_on = 1'b0;
endfunction

task automatic compare_value(input string what, input logic [12:0] a,
                             input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
        error_count++;
        $display("[ERROR] %0t ns: %s at 0x%04h is 0x%08h, expected 0x%08h",
                 $time, what, a, got, want);
    end
endtask

task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timeout at %0t ns: no %s handshake within %0d cycles", $time, what, TIMEOUT);
endtask

// -------------------------------------------------------------------------
// AXI4-Lite transactions
// -------------------------------------------------------------------------
task automatic take_response(input bit is_write, output logic [31:0] data,
                             output logic [1:0] resp);
    bit fire;
    fire = 1'b0;
    data = '0;
    resp = RESP_SLVERR;
    repeat ($urandom % 4) @(posedge clk);   // Back-pressure on B or R
    if (is_write)
        m2s.b_ready <= 1'b1;
    else
        m2s.r_ready <= 1'b1;
    for (int n = 0; n < TIMEOUT && !fire; n++) begin
        @(negedge clk);                     // Sample where stable
        fire = is_write ? s2m.b_valid : s2m.r_valid;
        data = s2m.r_data;
        resp = is_write ? s2m.b_resp : s2m.r_resp;
        @(posedge clk);
    end
    m2s.b_ready <= 1'b0;
    m2s.r_ready <= 1'b0;
    if (!fire)
        report_timeout(is_write ? "B" : "R");
endtask

task automatic axil_write(input logic [12:0] a, input logic [31:0] d,
                          output logic [1:0] resp);
    bit          aw_done;
    bit          w_done;
    bit          aw_fire;
    bit          w_fire;
    logic [31:0] unused_data;
    aw_done = 1'b0;
    w_done  = 1'b0;
    resp    = RESP_SLVERR;
    @(posedge clk);
    m2s.aw_valid <= 1'b1;
    m2s.aw_addr  <= a;
    m2s.w_valid  <= 1'b1;
    m2s.w_data   <= d;
    m2s.w_strb   <= '1;
    for (int n = 0; n < TIMEOUT && !(aw_done && w_done); n++) begin
        @(negedge clk);
        aw_fire = m2s.aw_valid && s2m.aw_ready;
        w_fire  = m2s.w_valid && s2m.w_ready;
        @(posedge clk);
        if (aw_fire) begin
            m2s.aw_valid <= 1'b0;           // AW taken on this edge
            aw_done = 1'b1;
        end
        if (w_fire) begin
            m2s.w_valid <= 1'b0;
            w_done = 1'b1;
        end
    end
    if (aw_done && w_done) begin
        take_response(1'b1, unused_data, resp);
    end else begin
        m2s.aw_valid <= 1'b0;
        m2s.w_valid  <= 1'b0;
        report_timeout("AW/W");
    end
endtask

task automatic axil_read(input logic [12:0] a, output logic [31:0] data,
                         output logic [1:0] resp);
    bit ar_done;
    bit ar_fire;
    ar_done = 1'b0;
    data    = '0;
    resp    = RESP_SLVERR;
    @(posedge clk);
    m2s.ar_valid <= 1'b1;
    m2s.ar_addr  <= a;
    for (int n = 0; n < TIMEOUT && !ar_done; n++) begin
        @(negedge clk);
        ar_fire = m2s.ar_valid && s2m.ar_ready;
        @(posedge clk);
        if (ar_fire) begin
            m2s.ar_valid <= 1'b0;
            ar_done = 1'b1;
        end
    end
    if (ar_done) begin
        take_response(1'b0, data, resp);
    end else begin
        m2s.ar_valid <= 1'b0;
        report_timeout("AR");
    end
endtask

// Bus access plus model update and response check
task automatic bus_write(input logic [12:0] a, input logic [31:0] d);
    logic [1:0] resp;
    logic [1:0] want;
    want = (decode_addr(a) == K_NONE) ? RESP_SLVERR : RESP_OKAY;
    axil_write(a, d, resp);
    model_write(a, d);
    compare_value("write response", a, 32'(resp), 32'(want));
endtask

task automatic bus_read(input logic [12:0] a);
    logic [31:0] data;
    logic [31:0] want;
    logic [1:0]  resp;
    bit          known;
    axil_read(a, data, resp);
    model_read(a, want, known);
    compare_value("read response", a, 32'(resp),
                  (decode_addr(a) == K_NONE) ? 32'(RESP_SLVERR) : 32'(RESP_OKAY));
    if (known)
        compare_value("read data", a, data, want);
endtask

// -------------------------------------------------------------------------
// Test sequences
// -------------------------------------------------------------------------
task automatic control_regs_test();
    logic [12:0] a;
    bus_read(REG_MODGN);                    // Reset values
    bus_read(REG_PHYSPG);
    bus_read(REG_PRIV);
    bus_read(REG_FILL);
    for (int i = 0; i < 30; i++) begin
        a = REG_MODGN + 13'(4 * ($urandom % 3));
        bus_write(a, $urandom);
        bus_read(a);
    end
    bus_write(REG_FILL, 32'hFFFF_FFFE);     // Bit 0 clear so the fill stays idle
    bus_read(REG_FILL);
    for (int i = 0; i < 10; i++) begin      // Gaps in the map
        if ($urandom % 2)
            a = 13'h018 + 13'(4 * ($urandom % 58));
        else
            a = 13'h180 + 13'(4 * ($urandom % 928));
        bus_read(a);
        bus_write(a, $urandom);
    end
    bus_read(REG_MODGN);
    bus_read(REG_PHYSPG);
    bus_read(REG_PRIV);
endtask

task automatic page_map_test();
    int q[$];
    int p;
    int j;
    for (int i = 0; i < 200; i++) begin
        p = $urandom % PAGE_CNT;
        if (!map_ok[p])
            q.push_back(p);
        bus_write(MAP_BASE + 13'(4 * p), $urandom);
    end
    for (int i = q.size() - 1; i > 0; i--) begin    // Shuffle read order
        j    = $urandom % (i + 1);
        p    = q[i];
        q[i] = q[j];
        q[j] = p;
    end
    foreach (q[i])
        bus_read(MAP_BASE + 13'(4 * q[i]));
endtask

task automatic access_bits_test();
    int q[$];
    int p;
    for (int i = 0; i < 40; i++) begin
        p = $urandom % PAGE_CNT;
        q.push_back(p);
        bus_write(REG_PHYSPG, 32'(p));
        bus_write(REG_ACCESS, $urandom);    // Bits 2:1 carry ro and inv
    end
    foreach (q[i]) begin
        bus_write(REG_PHYSPG, 32'((q[i] + 1) % PAGE_CNT));
        bus_write(REG_PHYSPG, 32'(q[i]));   // Back to the page
        bus_read(REG_ACCESS);
    end
endtask

task automatic modifier_test();
    logic [4:0] grp [4];
    bus_write(REG_PRIV, 32'd1);
    for (int g = 0; g < 4; g++)
        grp[g] = 5'($urandom);
    for (int i = 0; i < 64; i++) begin
        bus_write(REG_MODGN, 32'(grp[i % 4]));
        bus_write(MOD_BASE + 13'(4 * (1 + $urandom % 31)), $urandom);
    end
    bus_write(MOD_BASE, $urandom);          // M0 stays zero
    bus_read(MOD_BASE);
    bus_write(REG_PRIV, 32'd0);
    for (int k = MOD_PRIV_BASE; k < 32; k++) begin
        bus_write(MOD_BASE + 13'(4 * k), $urandom);
        bus_read(MOD_BASE + 13'(4 * k));
    end
    bus_write(REG_PRIV, 32'd1);             // Old values visible again
    for (int g = 0; g < 4; g++) begin
        bus_write(REG_MODGN, 32'(grp[g]));
        for (int k = 0; k < 32; k++)
            bus_read(MOD_BASE + 13'(4 * k));
    end
endtask

task automatic fill_test();
    int          start;
    int          low;
    int          n;
    logic [31:0] busy;
    logic [1:0]  resp;
    for (int i = 0; i < 40; i++) begin
        bus_write(REG_PHYSPG, $urandom % PAGE_CNT);
        bus_write(REG_REPRIO, $urandom);
    end
    start = 1 + $urandom % 512;
    low   = $urandom % start;               // Page below the fill
    bus_write(REG_PHYSPG, 32'(low));
    bus_write(REG_REPRIO, 32'd0);
    bus_write(REG_PHYSPG, 32'(start));
    bus_write(REG_FILL, 32'd1);
    bus_write(REG_PHYSPG, 32'(low));
    bus_write(REG_REPRIO, 32'd1);           // Lands mid-fill and is dropped
    axil_read(REG_FILL, busy, resp);
    compare_value("fill busy", REG_FILL, busy, 32'd1);
    for (n = 0; n < PAGE_CNT && busy[0]; n++)
        axil_read(REG_FILL, busy, resp);
    if (busy[0]) begin
        timeout_count++;
        $display("Timeout at %0t ns: fill still busy after %0d status reads", $time, n);
    end else begin
        fill_done();
    end
    for (int p = 0; p < PAGE_CNT; p++) begin
        bus_write(REG_PHYSPG, 32'(p));
        bus_read(REG_REPRIO);
    end
endtask

initial begin
    void'($urandom(SEED));
    m2s           = '0;
    reset         = 1'b1;
    error_count   = 0;
    timeout_count = 0;
    modgn_m       = '0;
    physpg_m      = '0;
    priv_m        = 1'b0;
    fill_on       = 1'b0;
    fill_from     = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    control_regs_test();
    if (timeout_count == 0)
        page_map_test();
    if (timeout_count == 0)
        access_bits_test();
    if (timeout_count == 0)
        modifier_test();
    if (timeout_count == 0)
        fill_test();
    $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
        $display("Simulation finished: PASS");
    else
        $display("Simulation finished: FAIL");
    $finish;
end

endmodule

`default_nettype wire

// File: besm_mmu.f
besm_mmu_pkg.sv
mmu_ram.sv
axil_slave.sv
modifier_mem.sv
page_attr_mem.sv
besm_mmu.sv
tb_besm_mmu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_besm_mmu
RTL_TOP   ?= besm_mmu
FILELIST  ?= besm_mmu.f
OBJ_DIR   ?= obj_dir
TSCALE    ?= --timescale 1ns/100ps
LINTFLAGS ?= --lint-only -Wall --timing $(TSCALE)
VFLAGS    ?= --binary --timing -Wno-fatal $(TSCALE)
PASS_MSG  := Simulation finished: PASS
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
